// ==== include/pad_dma_defs.svh ====
//**********************************************************
// Padding DMA shared constants
// Bus widths, tile geometry and word size
//**********************************************************

`ifndef PAD_DMA_DEFS_SVH
`define PAD_DMA_DEFS_SVH

// Bus widths
`define PAD_DATA_W      32
`define PAD_ADDR_W      32
`define PAD_MAT_W       6

// Tile and buffer edge in words
`define PAD_TILE        4
`define PAD_BUF         5

`define PAD_WORD_BYTES  4   // Byte stride of one word

`endif

// ==== source/pad_dma_pkg.sv ====
//**********************************************************
// Padding DMA types
// Vector types, FSM and block enums, bus structs
//**********************************************************

`include "pad_dma_defs.svh"

package pad_dma_pkg;

    typedef logic [`PAD_DATA_W-1:0] data_t;
    typedef logic [`PAD_ADDR_W-1:0] addr_t;
    typedef logic [`PAD_MAT_W-1:0]  mat_w_t;
    typedef logic [5:0]             blk_idx_t;
    typedef logic [3:0]             len_t;     // Burst length minus one
    typedef logic [2:0]             beat_t;    // Beat or row, 0 to 4

    typedef enum logic [3:0] {
        IDLE, RREQ, RDATA, PAD_ROW, PAD_COL, WREQ, WDATA, WRESP
    } ctrl_state_e;

    // Corners, edges, inner
    typedef enum logic [3:0] {
        TL, TR, BL, BR, T, B, L, R, INNER
    } blk_type_e;

    typedef struct packed {
        logic top;
        logic bottom;
        logic left;
        logic right;
    } edge_flags_t;

    // One-hot step strobes to the walker
    typedef struct packed {
        logic load;
        logic next_beat;
        logic next_row;
        logic next_block;
    } walk_cmd_t;

    typedef struct packed {
        addr_t addr;
        len_t  len;
        logic  valid;
    } ar_req_t;

    typedef struct packed {
        data_t data;
        logic  last;
        logic  valid;
    } r_beat_t;

    typedef struct packed {
        addr_t addr;
        len_t  len;
        logic  valid;
    } aw_req_t;

    typedef struct packed {
        data_t data;
        logic  last;
        logic  valid;
    } w_beat_t;

endpackage

// ==== source/pad_dma_ctrl.sv ====
//**********************************************************
// Padding DMA control FSM
// Per block: four read bursts, row and column padding,
// then one write burst and response per output row
//**********************************************************

`include "pad_dma_defs.svh"

module pad_dma_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   start_i,
    input  pad_dma_pkg::mat_w_t    mat_width_i,
    output logic                   done_o,
    output logic                   arvalid_o,
    input  logic                   arready_i,
    input  logic                   rvalid_i,
    input  logic                   rlast_i,
    output logic                   rready_o,
    output logic                   awvalid_o,
    input  logic                   awready_i,
    output logic                   wvalid_o,
    input  logic                   wready_i,
    input  logic                   wlast_i,
    input  logic                   bvalid_i,
    output logic                   bready_o,
    output pad_dma_pkg::walk_cmd_t walk_o,
    output logic                   store_o,
    output logic                   pad_rows_o,
    output logic                   pad_cols_o,
    input  logic                   tile_row_last_i,
    input  logic                   out_row_last_i,
    input  logic                   block_last_i
);
    import pad_dma_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;
    logic        width_ok;

    // Multiple of the tile edge and at least two tiles wide
    assign width_ok = ((mat_width_i % mat_w_t'(`PAD_TILE)) == '0)
                   && (mat_width_i >= mat_w_t'(2 * `PAD_TILE));

    assign done_o = (state_q == IDLE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin
        state_d    = state_q;
        walk_o     = '0;
        store_o    = 1'b0;
        pad_rows_o = 1'b0;
        pad_cols_o = 1'b0;
        arvalid_o  = 1'b0;
        rready_o   = 1'b0;
        awvalid_o  = 1'b0;
        wvalid_o   = 1'b0;
        bready_o   = 1'b0;

        case (state_q)
            IDLE: begin
                if (start_i && width_ok) begin
                    walk_o.load = 1'b1;
                    state_d     = RREQ;
                end
            end
            RREQ: begin
                arvalid_o = 1'b1;
                if (arready_i) begin
                    state_d = RDATA;
                end
            end
            RDATA: begin
                rready_o = 1'b1;
                if (rvalid_i) begin
                    store_o = 1'b1;
                    if (rlast_i) begin
                        walk_o.next_row = 1'b1;   // Also clears the beat
                        state_d = tile_row_last_i ? PAD_ROW : RREQ;
                    end else begin
                        walk_o.next_beat = 1'b1;
                    end
                end
            end
            PAD_ROW: begin
                pad_rows_o = 1'b1;
                state_d    = PAD_COL;
            end
            PAD_COL: begin
                pad_cols_o = 1'b1;   // Corners see padded rows
                state_d    = WREQ;
            end
            WREQ: begin
                awvalid_o = 1'b1;
                if (awready_i) begin
                    state_d = WDATA;
                end
            end
            WDATA: begin
                wvalid_o = 1'b1;
                if (wready_i) begin
                    if (wlast_i) begin
                        state_d = WRESP;
                    end else begin
                        walk_o.next_beat = 1'b1;
                    end
                end
            end
            WRESP: begin
                bready_o = 1'b1;
                if (bvalid_i) begin
                    if (!out_row_last_i) begin
                        walk_o.next_row = 1'b1;
                        state_d         = WREQ;
                    end else if (!block_last_i) begin
                        walk_o.next_block = 1'b1;
                        state_d           = RREQ;
                    end else begin
                        state_d = IDLE;
                    end
                end
            end
            default: state_d = IDLE;
        endcase
    end

    // Requests hold until accepted
    assert property (@(posedge clk) disable iff (!rst_n)
        arvalid_o && !arready_i |=> arvalid_o);
    assert property (@(posedge clk) disable iff (!rst_n)
        awvalid_o && !awready_i |=> awvalid_o);

endmodule

// ==== source/block_walker.sv ====
//**********************************************************
// Block walker
// Block, row and beat counters with block classification
//**********************************************************

`include "pad_dma_defs.svh"

module block_walker (
    input  logic                     clk,
    input  logic                     rst_n,
    input  pad_dma_pkg::walk_cmd_t   walk_i,
    input  pad_dma_pkg::mat_w_t      mat_width_i,
    output pad_dma_pkg::blk_idx_t    block_x_o,
    output pad_dma_pkg::blk_idx_t    block_y_o,
    output pad_dma_pkg::beat_t       tile_row_o,
    output pad_dma_pkg::beat_t       out_row_o,
    output pad_dma_pkg::beat_t       beat_o,
    output pad_dma_pkg::edge_flags_t flags_o,
    output logic                     tile_row_last_o,
    output logic                     out_row_last_o,
    output logic                     block_last_o
);
    import pad_dma_pkg::*;

    mat_w_t    width_q;
    blk_idx_t  bx_q;
    blk_idx_t  by_q;
    blk_idx_t  nblk;
    beat_t     tile_row_q;
    beat_t     out_row_q;
    beat_t     beat_q;
    blk_type_e blk_type;
    logic      x_last;
    logic      y_last;

    assign nblk   = blk_idx_t'(width_q / mat_w_t'(`PAD_TILE));
    assign x_last = (bx_q == nblk - 1'b1);
    assign y_last = (by_q == nblk - 1'b1);

    always_comb begin
        if (by_q == '0) begin
            blk_type = (bx_q == '0) ? TL : (x_last ? TR : T);
        end else if (y_last) begin
            blk_type = (bx_q == '0) ? BL : (x_last ? BR : B);
        end else begin
            blk_type = (bx_q == '0) ? L : (x_last ? R : INNER);
        end
    end

    assign flags_o.top    = blk_type inside {TL, TR, T};
    assign flags_o.bottom = blk_type inside {BL, BR, B};
    assign flags_o.left   = blk_type inside {TL, BL, L};
    assign flags_o.right  = blk_type inside {TR, BR, R};

    always_ff @(posedge clk) begin
        if (!rst_n || walk_i.load) begin
            width_q    <= rst_n ? mat_width_i : '0;
            bx_q       <= '0;
            by_q       <= '0;
            tile_row_q <= '0;
            out_row_q  <= '0;
            beat_q     <= '0;
        end else if (walk_i.next_beat) begin
            beat_q <= beat_q + 1'b1;
        end else if (walk_i.next_row) begin
            beat_q <= '0;
            // Tile row parks at PAD_TILE once all reads are in
            if (tile_row_q != beat_t'(`PAD_TILE)) begin
                tile_row_q <= tile_row_q + 1'b1;
            end else begin
                out_row_q <= out_row_q + 1'b1;
            end
        end else if (walk_i.next_block) begin
            bx_q       <= x_last ? '0 : bx_q + 1'b1;
            by_q       <= x_last ? by_q + 1'b1 : by_q;
            tile_row_q <= '0;
            out_row_q  <= '0;
            beat_q     <= '0;
        end
    end

    assign block_x_o       = bx_q;
    assign block_y_o       = by_q;
    assign tile_row_o      = tile_row_q;
    assign out_row_o       = out_row_q;
    assign beat_o          = beat_q;
    assign tile_row_last_o = (tile_row_q == beat_t'(`PAD_TILE - 1));
    assign out_row_last_o  = (flags_o.top || flags_o.bottom)
                           ? (out_row_q == beat_t'(`PAD_BUF - 1))
                           : (out_row_q == beat_t'(`PAD_TILE - 1));
    assign block_last_o    = x_last && y_last;

    assert property (@(posedge clk) disable iff (!rst_n)
        (nblk != '0) |-> (bx_q < nblk));

endmodule

// ==== source/tile_addr_gen.sv ====
//**********************************************************
// Tile address generator
// Source row and padded destination row addresses
//**********************************************************

`include "pad_dma_defs.svh"

module tile_addr_gen (
    input  pad_dma_pkg::addr_t       src_addr_i,
    input  pad_dma_pkg::addr_t       dst_addr_i,
    input  pad_dma_pkg::mat_w_t      mat_width_i,
    input  pad_dma_pkg::blk_idx_t    block_x_i,
    input  pad_dma_pkg::blk_idx_t    block_y_i,
    input  pad_dma_pkg::beat_t       tile_row_i,
    input  pad_dma_pkg::beat_t       out_row_i,
    input  pad_dma_pkg::edge_flags_t flags_i,
    output pad_dma_pkg::addr_t       araddr_o,
    output pad_dma_pkg::addr_t       awaddr_o,
    output pad_dma_pkg::len_t        awlen_o
);
    import pad_dma_pkg::*;

    addr_t src_row;
    addr_t src_col;
    addr_t dst_row;
    addr_t dst_col;
    addr_t stride;

    // Source side in words
    assign src_row = addr_t'(block_y_i) * `PAD_TILE + addr_t'(tile_row_i);
    assign src_col = addr_t'(block_x_i) * `PAD_TILE;

    assign araddr_o = src_addr_i
                    + (src_row * addr_t'(mat_width_i) + src_col) * `PAD_WORD_BYTES;

    // Skip the pad row or column unless this block writes it
    assign dst_row = addr_t'(block_y_i) * `PAD_TILE + addr_t'(out_row_i)
                   + addr_t'(!flags_i.top);
    assign dst_col = addr_t'(block_x_i) * `PAD_TILE + addr_t'(!flags_i.left);
    assign stride  = addr_t'(mat_width_i) + 2;   // Padded width

    assign awaddr_o = dst_addr_i + (dst_row * stride + dst_col) * `PAD_WORD_BYTES;

    assign awlen_o = (flags_i.left || flags_i.right) ? len_t'(`PAD_BUF - 1)
                                                     : len_t'(`PAD_TILE - 1);

endmodule

// ==== source/tile_buffer.sv ====
//**********************************************************
// Tile buffer
// 5x5 word store with mirror padding and row readout
//**********************************************************

`include "pad_dma_defs.svh"

module tile_buffer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     store_i,
    input  pad_dma_pkg::data_t       rdata_i,
    input  pad_dma_pkg::beat_t       tile_row_i,
    input  pad_dma_pkg::beat_t       beat_i,
    input  pad_dma_pkg::edge_flags_t flags_i,
    input  logic                     pad_rows_i,
    input  logic                     pad_cols_i,
    input  pad_dma_pkg::beat_t       out_row_i,
    output pad_dma_pkg::data_t       wdata_o
);
    import pad_dma_pkg::*;

    localparam int MIRROR = 2;   // One in from the outer edge
    localparam int LAST   = `PAD_BUF - 1;

    data_t mem [`PAD_BUF][`PAD_BUF];
    beat_t wr_row;
    beat_t wr_col;

    // Leave row 0 or column 0 free for the top or left pad
    assign wr_row = tile_row_i + beat_t'(flags_i.top);
    assign wr_col = beat_i + beat_t'(flags_i.left);

    always_ff @(posedge clk) begin
        if (store_i) begin
            mem[wr_row][wr_col] <= rdata_i;
        end else if (pad_rows_i) begin
            for (int c = 0; c < `PAD_BUF; c++) begin
                if (flags_i.top) begin
                    mem[0][c] <= mem[MIRROR][c];
                end
                if (flags_i.bottom) begin
                    mem[LAST][c] <= mem[MIRROR][c];
                end
            end
        end else if (pad_cols_i) begin
            // Rows already padded, so corners come out right
            for (int r = 0; r < `PAD_BUF; r++) begin
                if (flags_i.left) begin
                    mem[r][0] <= mem[r][MIRROR];
                end
                if (flags_i.right) begin
                    mem[r][LAST] <= mem[r][MIRROR];
                end
            end
        end
    end

    assign wdata_o = mem[out_row_i][beat_i];

    assert property (@(posedge clk) disable iff (!rst_n)
        store_i |-> !(pad_rows_i || pad_cols_i));

endmodule

// ==== source/pad_dma_top.sv ====
//**********************************************************
// Padding DMA top level
// Control, walker, address generator and tile buffer
//**********************************************************

`include "pad_dma_defs.svh"

module pad_dma_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 start_i,
    input  pad_dma_pkg::addr_t   src_addr_i,
    input  pad_dma_pkg::addr_t   dst_addr_i,
    input  pad_dma_pkg::mat_w_t  mat_width_i,
    output logic                 done_o,
    output pad_dma_pkg::ar_req_t ar_o,
    input  logic                 arready_i,
    input  pad_dma_pkg::r_beat_t r_i,
    output logic                 rready_o,
    output pad_dma_pkg::aw_req_t aw_o,
    input  logic                 awready_i,
    output pad_dma_pkg::w_beat_t w_o,
    input  logic                 wready_i,
    input  logic                 bvalid_i,
    output logic                 bready_o
);
    import pad_dma_pkg::*;

    walk_cmd_t   walk;
    logic        store;
    logic        pad_rows;
    logic        pad_cols;
    blk_idx_t    block_x;
    blk_idx_t    block_y;
    beat_t       tile_row;
    beat_t       out_row;
    beat_t       beat;
    edge_flags_t flags;
    logic        tile_row_last;
    logic        out_row_last;
    logic        block_last;
    addr_t       araddr;
    addr_t       awaddr;
    len_t        awlen;
    data_t       wdata;
    logic        arvalid;
    logic        awvalid;
    logic        wvalid;
    logic        wlast;

    assign wlast = (len_t'(beat) == awlen);   // Final beat of the row burst

    assign ar_o = '{addr: araddr, len: len_t'(`PAD_TILE - 1), valid: arvalid};
    assign aw_o = '{addr: awaddr, len: awlen, valid: awvalid};
    assign w_o  = '{data: wdata, last: wlast, valid: wvalid};

    pad_dma_ctrl i_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .start_i         (start_i),
        .mat_width_i     (mat_width_i),
        .done_o          (done_o),
        .arvalid_o       (arvalid),
        .arready_i       (arready_i),
        .rvalid_i        (r_i.valid),
        .rlast_i         (r_i.last),
        .rready_o        (rready_o),
        .awvalid_o       (awvalid),
        .awready_i       (awready_i),
        .wvalid_o        (wvalid),
        .wready_i        (wready_i),
        .wlast_i         (wlast),
        .bvalid_i        (bvalid_i),
        .bready_o        (bready_o),
        .walk_o          (walk),
        .store_o         (store),
        .pad_rows_o      (pad_rows),
        .pad_cols_o      (pad_cols),
        .tile_row_last_i (tile_row_last),
        .out_row_last_i  (out_row_last),
        .block_last_i    (block_last)
    );

    block_walker i_walker (
        .clk             (clk),
        .rst_n           (rst_n),
        .walk_i          (walk),
        .mat_width_i     (mat_width_i),
        .block_x_o       (block_x),
        .block_y_o       (block_y),
        .tile_row_o      (tile_row),
        .out_row_o       (out_row),
        .beat_o          (beat),
        .flags_o         (flags),
        .tile_row_last_o (tile_row_last),
        .out_row_last_o  (out_row_last),
        .block_last_o    (block_last)
    );

    tile_addr_gen i_addr_gen (
        .src_addr_i  (src_addr_i),
        .dst_addr_i  (dst_addr_i),
        .mat_width_i (mat_width_i),
        .block_x_i   (block_x),
        .block_y_i   (block_y),
        .tile_row_i  (tile_row),
        .out_row_i   (out_row),
        .flags_i     (flags),
        .araddr_o    (araddr),
        .awaddr_o    (awaddr),
        .awlen_o     (awlen)
    );

    tile_buffer i_buffer (
        .clk        (clk),
        .rst_n      (rst_n),
        .store_i    (store),
        .rdata_i    (r_i.data),
        .tile_row_i (tile_row),
        .beat_i     (beat),
        .flags_i    (flags),
        .pad_rows_i (pad_rows),
        .pad_cols_i (pad_cols),
        .out_row_i  (out_row),
        .wdata_o    (wdata)
    );

endmodule

// ==== tests/axi_mem_model.sv ====
//**********************************************************
// Bus memory model
// Word memory behind valid/ready read and write channels
//**********************************************************

`include "pad_dma_defs.svh"

module axi_mem_model (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic [4:0]           stall_i,      // ar, r, aw, w, b from msb down
    input  pad_dma_pkg::ar_req_t ar_i,
    output logic                 arready_o,
    output pad_dma_pkg::r_beat_t r_o,
    input  logic                 rready_i,
    input  pad_dma_pkg::aw_req_t aw_i,
    output logic                 awready_o,
    input  pad_dma_pkg::w_beat_t w_i,
    output logic                 wready_o,
    output logic                 bvalid_o,
    input  logic                 bready_i,
    input  logic                 load_i,
    input  logic [8:0]           load_addr_i,
    input  pad_dma_pkg::data_t   load_data_i,
    output logic                 err_o,
    output int                   rd_bursts_o,
    output int                   wr_bursts_o,
    output pad_dma_pkg::addr_t   last_awaddr_o
);
    import pad_dma_pkg::*;

    localparam int DEPTH = 512;

    data_t      mem [DEPTH];
    logic       rd_active;
    logic [8:0] rd_ptr;
    len_t       rd_cnt;
    len_t       rd_len;
    logic       wr_active;
    logic [8:0] wr_ptr;
    len_t       wr_cnt;
    len_t       wr_len;
    logic       b_pend;    // Write response owed

    assign arready_o = !rd_active && !stall_i[4];
    assign r_o       = '{data: mem[rd_ptr], last: (rd_cnt == rd_len),
                         valid: rd_active && !stall_i[3]};
    assign awready_o = !wr_active && !b_pend && !stall_i[2];
    assign wready_o  = wr_active && !stall_i[1];
    assign bvalid_o  = b_pend && !stall_i[0];

    always_ff @(posedge clk) begin
        if (load_i) begin
            mem[load_addr_i] <= load_data_i;
        end else if (w_i.valid && wready_o) begin
            mem[wr_ptr] <= w_i.data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_active     <= 1'b0;
            rd_ptr        <= '0;
            rd_cnt        <= '0;
            rd_len        <= '0;
            wr_active     <= 1'b0;
            wr_ptr        <= '0;
            wr_cnt        <= '0;
            wr_len        <= '0;
            b_pend        <= 1'b0;
            err_o         <= 1'b0;
            rd_bursts_o   <= 0;
            wr_bursts_o   <= 0;
            last_awaddr_o <= '0;
        end else begin
            if (ar_i.valid && arready_o) begin
                if (ar_i.len != len_t'(`PAD_TILE - 1)) begin
                    $display("Read burst of %0d beats where 4 were expected",
                             int'(ar_i.len) + 1);
                    err_o <= 1'b1;
                end
                rd_active   <= 1'b1;
                rd_ptr      <= ar_i.addr[10:2];
                rd_cnt      <= '0;
                rd_len      <= ar_i.len;
                rd_bursts_o <= rd_bursts_o + 1;
            end
            if (r_o.valid && rready_i) begin
                rd_ptr <= rd_ptr + 1'b1;
                rd_cnt <= rd_cnt + 1'b1;
                if (r_o.last) begin
                    rd_active <= 1'b0;
                end
            end
            // Writes are strictly one burst at a time
            if (aw_i.valid && (wr_active || b_pend)) begin
                $display("Write burst requested before the previous response was taken");
                err_o <= 1'b1;
            end
            if (aw_i.valid && awready_o) begin
                if (aw_i.len != len_t'(3) && aw_i.len != len_t'(4)) begin
                    $display("Write burst of %0d beats where 4 or 5 were expected",
                             int'(aw_i.len) + 1);
                    err_o <= 1'b1;
                end
                wr_active     <= 1'b1;
                wr_ptr        <= aw_i.addr[10:2];
                wr_cnt        <= '0;
                wr_len        <= aw_i.len;
                wr_bursts_o   <= wr_bursts_o + 1;
                last_awaddr_o <= aw_i.addr;
            end
            if (w_i.valid && wready_o) begin
                if (w_i.last != (wr_cnt == wr_len)) begin
                    $display("Write last flag wrong on beat %0d of a %0d beat burst",
                             int'(wr_cnt) + 1, int'(wr_len) + 1);
                    err_o <= 1'b1;
                end
                wr_ptr <= wr_ptr + 1'b1;
                wr_cnt <= wr_cnt + 1'b1;
                if (wr_cnt == wr_len) begin
                    wr_active <= 1'b0;
                    b_pend    <= 1'b1;
                end
            end
            if (bvalid_o && bready_i) begin
                b_pend <= 1'b0;
            end
        end
    end

endmodule

// ==== tests/tb_pad_dma.sv ====
//**********************************************************
// Padding DMA testbench
// Directed runs checked against a mirror padding reference
//**********************************************************

`include "pad_dma_defs.svh"

module tb_pad_dma;
    import pad_dma_pkg::*;

    localparam int    MEM_WORDS = 512;
    localparam addr_t SRC_BASE  = 32'h0000_0000;
    localparam addr_t DST_BASE  = 32'h0000_0400;
    localparam int    TIMEOUT   = 20000;   // Cycles per run

    logic        clk;
    logic        rst_n;
    logic        start;
    addr_t       src_addr;
    addr_t       dst_addr;
    mat_w_t      mat_width;
    logic        done;
    ar_req_t     ar;
    logic        arready;
    r_beat_t     r;
    logic        rready;
    aw_req_t     aw;
    logic        awready;
    w_beat_t     w;
    logic        wready;
    logic        bvalid;
    logic        bready;
    logic [4:0]  stall;
    logic        load;
    logic [8:0]  load_addr;
    data_t       load_data;
    logic        mem_err;
    int          rd_bursts;
    int          wr_bursts;
    addr_t       last_awaddr;
    logic [31:0] lfsr;
    data_t       image [MEM_WORDS];   // Memory contents before the run

    pad_dma_top i_pad_dma_top (
        .clk(clk), .rst_n(rst_n), .start_i(start),
        .src_addr_i(src_addr), .dst_addr_i(dst_addr), .mat_width_i(mat_width),
        .done_o(done), .ar_o(ar), .arready_i(arready), .r_i(r), .rready_o(rready),
        .aw_o(aw), .awready_i(awready), .w_o(w), .wready_i(wready),
        .bvalid_i(bvalid), .bready_o(bready)
    );

    axi_mem_model i_mem (
        .clk(clk), .rst_n(rst_n), .stall_i(stall),
        .ar_i(ar), .arready_o(arready), .r_o(r), .rready_i(rready),
        .aw_i(aw), .awready_o(awready), .w_i(w), .wready_o(wready),
        .bvalid_o(bvalid), .bready_i(bready),
        .load_i(load), .load_addr_i(load_addr), .load_data_i(load_data),
        .err_o(mem_err), .rd_bursts_o(rd_bursts), .wr_bursts_o(wr_bursts),
        .last_awaddr_o(last_awaddr)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        if (mem_err) begin
            $display("Memory model saw a bus protocol violation");
            $display("Regression failed");
            $fatal(1);
        end
    end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    // One LFSR step per bit taken
    task automatic take_bits(input int count, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < count; k++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr_step(lfsr);
        end
    endtask

    function automatic data_t marker(input int idx);
        return 32'hface_0000 | 32'(idx);
    endfunction

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error at time %0t: %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t exp);
        if (got !== exp) begin
            abort_run($sformatf("error at time %0t: %s got %h expected %h",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            abort_run($sformatf("error at time %0t: %s got %b expected %b",
                                $time, name, got, exp));
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        if (got != exp) begin
            abort_run($sformatf("error at time %0t: %s got %0d expected %0d",
                                $time, name, got, exp));
        end
    endtask

    // Pad row -1 mirrors row 1, pad row W mirrors row W-2, columns alike
    function automatic data_t padded_word(input int width, input int row, input int col);
        int sr;
        int sc;
        int idx;
        sr = row - 1;
        sc = col - 1;
        if (sr < 0) sr = 1;
        if (sr > width - 1) sr = width - 2;
        if (sc < 0) sc = 1;
        if (sc > width - 1) sc = width - 2;
        idx = int'(SRC_BASE >> 2) + sr * width + sc;
        return image[9'(idx)];
    endfunction

    // Random source, address marker everywhere else
    task automatic fill_memory(input int width);
        logic [31:0] word;
        for (int i = 0; i < MEM_WORDS; i++) begin
            if (i < width * width) begin
                take_bits(32, word);
            end else begin
                word = marker(i);
            end
            image[9'(i)] = word;
            @(negedge clk);
            load      = 1'b1;
            load_addr = 9'(i);
            load_data = word;
        end
        @(negedge clk);
        load = 1'b0;
    endtask

    task automatic run_dma(input int width, input logic stalls);
        logic [31:0] bits;
        int          n;
        @(negedge clk);
        mat_width = mat_w_t'(width);
        start     = 1'b1;
        @(negedge clk);
        start = 1'b0;
        check_bit("done_o", done, 1'b0);
        n = 0;
        while (!done) begin
            if (stalls) begin
                take_bits(5, bits);
                stall = bits[4:0];
            end
            @(negedge clk);
            n++;
            if (n > TIMEOUT) begin
                abort_run("Timed out waiting for done_o to rise");
            end
        end
        stall = '0;
    endtask

    task automatic check_memory(input int width);
        int dst0;
        int pw;
        int off;
        dst0 = int'(DST_BASE >> 2);
        pw   = width + 2;
        for (int i = 0; i < MEM_WORDS; i++) begin
            off = i - dst0;
            if (off >= 0 && off < pw * pw) begin
                check_data($sformatf("mem[%0d]", i), i_mem.mem[9'(i)],
                           padded_word(width, off / pw, off % pw));
            end else begin
                check_data($sformatf("mem[%0d]", i), i_mem.mem[9'(i)], image[9'(i)]);
            end
        end
    endtask

    task automatic test_idle_and_bad_width;
        int rd0;
        int wr0;
        check_bit("done_o", done, 1'b1);
        check_bit("ar_o.valid", ar.valid, 1'b0);
        check_bit("aw_o.valid", aw.valid, 1'b0);
        check_bit("w_o.valid", w.valid, 1'b0);
        check_bit("rready_o", rready, 1'b0);
        check_bit("bready_o", bready, 1'b0);
        rd0 = rd_bursts;
        wr0 = wr_bursts;
        for (int k = 0; k < 2; k++) begin
            @(negedge clk);
            mat_width = (k == 0) ? mat_w_t'(6) : mat_w_t'(4);
            start     = 1'b1;
            @(negedge clk);
            start = 1'b0;
            repeat (20) begin   // Observation window
                @(negedge clk);
                check_bit("done_o", done, 1'b1);
                check_bit("ar_o.valid", ar.valid, 1'b0);
                check_bit("aw_o.valid", aw.valid, 1'b0);
            end
        end
        check_count("read bursts", rd_bursts - rd0, 0);
        check_count("write bursts", wr_bursts - wr0, 0);
    endtask

    task automatic test_padding(input int width, input logic stalls);
        int    rd0;
        int    wr0;
        int    nblk;
        addr_t last_row;
        fill_memory(width);
        rd0 = rd_bursts;
        wr0 = wr_bursts;
        run_dma(width, stalls);
        check_memory(width);
        nblk = width / `PAD_TILE;
        check_count("read bursts", rd_bursts - rd0, nblk * nblk * 4);
        check_count("write bursts", wr_bursts - wr0, nblk * (2 * 5 + (nblk - 2) * 4));
        // Final burst covers columns W-3 to W+1 of the last padded row
        last_row = addr_t'(((width + 1) * (width + 2) + width - 3) * 4);
        check_addr("last awaddr", last_awaddr, DST_BASE + last_row);
    endtask

    initial begin
        lfsr      = 32'd99262;
        rst_n     = 1'b0;
        start     = 1'b0;
        src_addr  = SRC_BASE;
        dst_addr  = DST_BASE;
        mat_width = '0;
        stall     = '0;
        load      = 1'b0;
        load_addr = '0;
        load_data = '0;
        repeat (8) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_idle_and_bad_width();
        test_padding(8, 1'b0);
        test_padding(12, 1'b0);
        test_padding(12, 1'b1);   // Random stalls on all channels
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== pad_dma.f ====
+incdir+include
source/pad_dma_pkg.sv
source/pad_dma_ctrl.sv
source/block_walker.sv
source/tile_addr_gen.sv
source/tile_buffer.sv
source/pad_dma_top.sv
tests/axi_mem_model.sv
tests/tb_pad_dma.sv

// ==== Makefile ====
# Verilator flow for the padding DMA

RTL = source/pad_dma_pkg.sv source/pad_dma_ctrl.sv source/block_walker.sv \
      source/tile_addr_gen.sv source/tile_buffer.sv source/pad_dma_top.sv

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall +incdir+include --top-module pad_dma_top $(RTL)

sim:
	verilator --binary --timing --assert -f pad_dma.f --top-module tb_pad_dma -o sim_tb
	./obj_dir/sim_tb | tee sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
